// ==== filelist.f ====
logic/dds_lab_pkg.sv
logic/dds_wave_gen.sv
logic/lfsr_bit_source.sv
logic/modulation_select.sv
logic/key_hold_tracker.sv
logic/apb_ctrl_regs.sv
logic/dds_lab_top.sv
verif/dds_lab_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = dds_lab_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/dds_lab_tb.sv ====
`timescale 1ns/1ps

module dds_lab_tb import dds_lab_pkg::*; ();

   logic                      video_clk_40Mhz;
   logic                      reset_from_key;
   logic                      psel;
   logic                      penable;
   logic                      pwrite;
   logic [apb_addr_width-1:0] paddr;
   logic [31:0]               pwdata;
   logic [31:0]               prdata;
   logic                      key_event_valid;
   logic [7:0]                key_event_code;
   logic [sample_width-1:0]   mod_sample;
   logic [sample_width-1:0]   wave_sample;
   logic                      data_bit_q;

   // check enables, driven on the falling edge
   logic        rd_check;
   logic [31:0] exp_rdata;
   logic        ask_check;
   logic        bpsk_check;
   logic        lfsr_check;
   logic        seq_check;
   logic        saw_check;
   logic        fsk_check;
   logic        sq_check;
   logic [11:0] saw_step;

   // reference lfsr
   logic [4:0]  lfsr_model;
   logic [31:0] lfsr_cnt;
   logic [31:0] period_model;
   logic        model_bit_q;

   logic [31:0]         lcg_state;
   logic [num_keys-1:0] key_model;
   int                  err_count;
   int                  test_err_start;
   int                  tests_run;
   int                  tests_failed;

   dds_lab_top DUT (
      .video_clk_40Mhz (video_clk_40Mhz),
      .reset_from_key  (reset_from_key),
      .psel            (psel),
      .penable         (penable),
      .pwrite          (pwrite),
      .paddr           (paddr),
      .pwdata          (pwdata),
      .prdata          (prdata),
      .key_event_valid (key_event_valid),
      .key_event_code  (key_event_code),
      .mod_sample      (mod_sample),
      .wave_sample     (wave_sample),
      .data_bit_q      (data_bit_q)
   );

   initial begin
      video_clk_40Mhz = 1'b0;
      forever #10 video_clk_40Mhz = ~video_clk_40Mhz;  // 20 ns period
   end

   // x^5 + x^3 + 1 from the seed, one shift per bit period
   always @(posedge video_clk_40Mhz) begin
      if (reset_from_key) begin
         lfsr_cnt    <= 32'd0;
         lfsr_model  <= lfsr_seed;
         model_bit_q <= 1'b1;
      end else begin
         model_bit_q <= lfsr_model[0];
         if (lfsr_cnt == period_model - 32'd1) begin
            lfsr_cnt   <= 32'd0;
            lfsr_model <= {lfsr_model[3:0], lfsr_model[4] ^ lfsr_model[2]};
         end else begin
            lfsr_cnt <= lfsr_cnt + 32'd1;
         end
      end
   end

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return {lcg_state[31:16], lcg_state[15:0] ^ lcg_state[31:16]};
   endfunction

   function automatic logic [31:0] mode_word(input logic [1:0] mod, input logic [1:0] sig);
      return {28'd0, mod, sig};
   endfunction

   // offset binary sine from the top bits of the phase
   function automatic logic [11:0] sine_from_saw(input logic [11:0] saw);
      logic [5:0] a;
      int         t;
      a = saw[10] ? 6'd63 - saw[9:4] : saw[9:4];  // second and fourth quarter run backwards
      t = int'(quarter_sine[a]);
      if (saw[11]) begin
         return 12'(2047 - t);
      end
      return 12'(2048 + t);
   endfunction

   task automatic log_mismatch(input string msg);
      err_count++;
      $display("FAILED %0t: %s", $time, msg);
   endtask

   task automatic report_timeout(input string what);
      $display("timeout: %s did not happen in time", what);
      $display("TESTS FAILED");
      $finish;
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (err_count != test_err_start) begin
         tests_failed++;
         $display("test %0d %s: %0d errors", tests_run, name, err_count - test_err_start);
      end else begin
         $display("test %0d %s: ok", tests_run, name);
      end
      test_err_start = err_count;
   endtask

   task automatic apply_reset();
      reset_from_key = 1'b1;
      period_model   = 32'd16;
      repeat (16) @(negedge video_clk_40Mhz);
      reset_from_key = 1'b0;
   endtask

   task automatic settle(input int n);
      repeat (n) @(negedge video_clk_40Mhz);
   endtask

   //////////////////////////////////////////////////
   // apb and key drivers
   //////////////////////////////////////////////////
   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge video_clk_40Mhz);
      penable = 1'b1;  // access phase, register takes it on the next edge
      @(negedge video_clk_40Mhz);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      if (addr == reg_bit_period) begin
         period_model = data;
      end
   endtask

   task automatic apb_read(input logic [7:0] addr, input logic [31:0] expected);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge video_clk_40Mhz);
      penable   = 1'b1;
      exp_rdata = expected;
      rd_check  = 1'b1;
      @(negedge video_clk_40Mhz);
      psel     = 1'b0;
      penable  = 1'b0;
      rd_check = 1'b0;
   endtask

   task automatic send_key(input logic [7:0] code);
      key_event_valid = 1'b1;
      key_event_code  = code;
      @(negedge video_clk_40Mhz);
      key_event_valid = 1'b0;
   endtask

   task automatic watch_bits(input int changes, input int limit, input string what);
      int   seen;
      int   cycles;
      logic last;
      seen   = 0;
      cycles = 0;
      last   = data_bit_q;
      while (seen < changes && cycles < limit) begin
         @(negedge video_clk_40Mhz);
         cycles++;
         if (data_bit_q != last) begin
            seen++;
            last = data_bit_q;
         end
      end
      if (seen < changes) begin
         report_timeout(what);
      end
   endtask

   task automatic watch_square_levels(input int limit);
      int cycles;
      bit seen_low;
      bit seen_high;
      cycles    = 0;
      seen_low  = 1'b0;
      seen_high = 1'b0;
      while (!(seen_low && seen_high) && cycles < limit) begin
         @(negedge video_clk_40Mhz);
         cycles++;
         seen_low  = seen_low | (wave_sample == 12'h000);
         seen_high = seen_high | (wave_sample == 12'hFFF);
      end
      if (!(seen_low && seen_high)) begin
         report_timeout("square wave reaching both levels");
      end
   endtask

   //////////////////////////////////////////////////
   // checkers
   //////////////////////////////////////////////////
   a_readback: assert property (@(posedge video_clk_40Mhz) disable iff (reset_from_key)
      (rd_check && psel && penable && !pwrite) |-> prdata == exp_rdata)
      else log_mismatch($sformatf("read 0x%02h gave 0x%08h, expected 0x%08h",
                                  paddr, prdata, exp_rdata));

   a_ask: assert property (@(posedge video_clk_40Mhz) disable iff (reset_from_key)
      ask_check |-> (data_bit_q ? mod_sample == wave_sample : mod_sample == 12'h000))
      else log_mismatch("ask sample does not follow the data bit");

   a_bpsk: assert property (@(posedge video_clk_40Mhz) disable iff (reset_from_key)
      bpsk_check |-> mod_sample == (data_bit_q ? wave_sample : ~wave_sample))
      else log_mismatch("bpsk sample does not follow the data bit");

   a_lfsr_level: assert property (@(posedge video_clk_40Mhz) disable iff (reset_from_key)
      lfsr_check |-> mod_sample == (data_bit_q ? 12'h000 : 12'h800))
      else log_mismatch($sformatf("lfsr mode sample 0x%03h", mod_sample));

   a_lfsr_seq: assert property (@(posedge video_clk_40Mhz) disable iff (reset_from_key)
      seq_check |-> data_bit_q == model_bit_q)
      else log_mismatch("data bit off the reference lfsr sequence");

   a_saw_step: assert property (@(posedge video_clk_40Mhz) disable iff (reset_from_key)
      saw_check |-> 12'(wave_sample - $past(wave_sample)) == saw_step)
      else log_mismatch($sformatf("sawtooth step wrong, expected %0d", saw_step));

   a_fsk_sine: assert property (@(posedge video_clk_40Mhz) disable iff (reset_from_key)
      fsk_check |-> mod_sample == sine_from_saw(wave_sample))
      else log_mismatch($sformatf("fsk sample 0x%03h not the sine of phase 0x%03h",
                                  mod_sample, wave_sample));

   a_square: assert property (@(posedge video_clk_40Mhz) disable iff (reset_from_key)
      sq_check |-> (wave_sample == 12'h000 || wave_sample == 12'hFFF))
      else log_mismatch($sformatf("square sample 0x%03h", wave_sample));

   //////////////////////////////////////////////////
   // test sequence
   //////////////////////////////////////////////////
   initial begin
      logic [31:0] r;
      logic [31:0] p;
      logic [31:0] mode_v;
      logic [31:0] base_v;
      logic [31:0] fsk_v;
      logic [31:0] period_v;
      logic [7:0]  code;
      int          idx;
      reset_from_key  = 1'b1;
      psel            = 1'b0;
      penable         = 1'b0;
      pwrite          = 1'b0;
      paddr           = '0;
      pwdata          = '0;
      key_event_valid = 1'b0;
      key_event_code  = '0;
      rd_check        = 1'b0;
      ask_check       = 1'b0;
      bpsk_check      = 1'b0;
      lfsr_check      = 1'b0;
      seq_check       = 1'b0;
      saw_check       = 1'b0;
      fsk_check       = 1'b0;
      sq_check        = 1'b0;
      exp_rdata      = '0;
      saw_step       = '0;
      period_model   = 32'd16;
      key_model      = '0;
      lcg_state      = 32'd86640;
      err_count      = 0;
      test_err_start = 0;
      tests_run      = 0;
      tests_failed   = 0;
      apply_reset();

      mode_v = next_rand();
      apb_write(reg_mode, mode_v);
      mode_v = mode_v & 32'h0000_000F;  // only sig_sel and mod_sel stick
      apb_read(reg_mode, mode_v);
      base_v = next_rand();
      apb_write(reg_base_word, base_v);
      apb_read(reg_base_word, base_v);
      fsk_v = next_rand();
      apb_write(reg_fsk_word, fsk_v);
      apb_read(reg_fsk_word, fsk_v);
      period_v = next_rand();
      apb_write(reg_bit_period, period_v);
      apb_read(reg_bit_period, period_v);
      apb_write(reg_keys, next_rand());
      apb_read(reg_keys, 32'd0);
      apb_write(8'h14, next_rand());  // unmapped
      apb_read(8'h14, 32'd0);
      // neither write above may land in a real register
      apb_read(reg_mode, mode_v);
      apb_read(reg_base_word, base_v);
      apb_read(reg_fsk_word, fsk_v);
      apb_read(reg_bit_period, period_v);
      end_test("register readback");

      for (int n = 0; n < 40; n++) begin
         r   = next_rand();
         idx = int'(r[20:16]) % num_keys;
         if (r[9:7] == 3'd0) begin
            code = 8'h1E;  // not in the key table
         end else if (r[24]) begin
            code           = key_make_codes[idx];
            key_model[idx] = 1'b1;
         end else begin
            code           = key_make_codes[idx] | 8'h80;
            key_model[idx] = 1'b0;
         end
         send_key(code);
         apb_read(reg_keys, {15'd0, key_model});
      end
      end_test("key tracking");

      apb_write(reg_bit_period, 32'd5);
      apb_write(reg_mode, mode_word(mod_sel_ask, sig_sel_sine));
      settle(2);
      ask_check = 1'b1;
      watch_bits(6, 500, "ask data bit changes");
      ask_check = 1'b0;
      apb_write(reg_mode, mode_word(mod_sel_bpsk, sig_sel_sine));
      settle(2);
      bpsk_check = 1'b1;
      watch_bits(6, 500, "bpsk data bit changes");
      bpsk_check = 1'b0;
      end_test("ask and bpsk");

      // period written right after reset so the lfsr runs as if programmed from the seed
      p = 32'd4 + next_rand() % 32'd8;
      apply_reset();
      seq_check = 1'b1;
      apb_write(reg_bit_period, p);
      apb_write(reg_mode, mode_word(mod_sel_lfsr, sig_sel_sine));
      settle(2);
      lfsr_check = 1'b1;
      watch_bits(10, 1500, "lfsr data bit changes");
      lfsr_check = 1'b0;
      seq_check  = 1'b0;
      end_test("lfsr mode and sequence");

      r = next_rand() % 32'd4095 + 32'd1;
      apb_write(reg_base_word, r << 20);
      apb_write(reg_mode, mode_word(mod_sel_ask, sig_sel_saw));
      saw_step = r[11:0];
      settle(3);
      saw_check = 1'b1;
      settle(64);
      saw_check = 1'b0;
      r = next_rand() % 32'd4095 + 32'd1;
      apb_write(reg_fsk_word, r << 20);
      apb_write(reg_mode, mode_word(mod_sel_fsk, sig_sel_saw));
      saw_step = r[11:0];
      settle(3);
      saw_check = 1'b1;
      fsk_check = 1'b1;
      settle(64);
      saw_check = 1'b0;
      fsk_check = 1'b0;
      end_test("sawtooth step and fsk");

      apb_write(reg_base_word, 32'h0400_0000);  // 64 cycle period
      apb_write(reg_mode, mode_word(mod_sel_ask, sig_sel_square));
      settle(2);
      sq_check = 1'b1;
      watch_square_levels(500);
      sq_check = 1'b0;
      end_test("square");

      $display("summary: %0d tests, %0d failed, %0d check errors",
               tests_run, tests_failed, err_count);
      if (err_count == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== logic/dds_lab_top.sv ====
`timescale 1ns/1ps

module dds_lab_top import dds_lab_pkg::*; (
   input  logic                      video_clk_40Mhz,
   input  logic                      reset_from_key,
   // apb control port
   input  logic                      psel,
   input  logic                      penable,
   input  logic                      pwrite,
   input  logic [apb_addr_width-1:0] paddr,
   input  logic [31:0]               pwdata,
   output logic [31:0]               prdata,
   // decoded keyboard events
   input  logic                      key_event_valid,
   input  logic [7:0]                key_event_code,
   // sample streams
   output logic [sample_width-1:0]   mod_sample,
   output logic [sample_width-1:0]   wave_sample,
   output logic                      data_bit_q
);

   mode_reg_u               mode;
   logic [31:0]             base_word;
   logic [31:0]             fsk_word;
   logic [31:0]             bit_period;
   logic [num_keys-1:0]     held_keys;
   logic [phase_width-1:0]  phase_inc;
   logic [sample_width-1:0] sin_out;
   logic [sample_width-1:0] cos_out;
   logic [sample_width-1:0] saw_out;
   logic [sample_width-1:0] squ_out;
   logic                    data_bit;

   //////////////////////////////////////////////////
   // control side
   //////////////////////////////////////////////////
   apb_ctrl_regs u_regs (
      .video_clk_40Mhz (video_clk_40Mhz),
      .reset_from_key  (reset_from_key),
      .psel            (psel),
      .penable         (penable),
      .pwrite          (pwrite),
      .paddr           (paddr),
      .pwdata          (pwdata),
      .held_keys       (held_keys),
      .prdata          (prdata),
      .mode            (mode),
      .base_word       (base_word),
      .fsk_word        (fsk_word),
      .bit_period      (bit_period)
   );

   key_hold_tracker u_keys (
      .video_clk_40Mhz (video_clk_40Mhz),
      .reset_from_key  (reset_from_key),
      .key_event_valid (key_event_valid),
      .key_event_code  (key_event_code),
      .held_keys       (held_keys)
   );

   //////////////////////////////////////////////////
   // signal path
   //////////////////////////////////////////////////
   lfsr_bit_source u_lfsr (
      .video_clk_40Mhz (video_clk_40Mhz),
      .reset_from_key  (reset_from_key),
      .bit_period      (bit_period),
      .data_bit        (data_bit)
   );

   dds_wave_gen u_dds (
      .video_clk_40Mhz (video_clk_40Mhz),
      .reset_from_key  (reset_from_key),
      .phase_inc       (phase_inc),  // base or fsk word
      .sin_out         (sin_out),
      .cos_out         (cos_out),
      .saw_out         (saw_out),
      .squ_out         (squ_out)
   );

   modulation_select u_mod (
      .video_clk_40Mhz (video_clk_40Mhz),
      .reset_from_key  (reset_from_key),
      .mode            (mode),
      .base_word       (base_word),
      .fsk_word        (fsk_word),
      .sin_in          (sin_out),
      .cos_in          (cos_out),
      .saw_in          (saw_out),
      .squ_in          (squ_out),
      .data_bit        (data_bit),
      .phase_inc       (phase_inc),
      .mod_sample      (mod_sample),
      .wave_sample     (wave_sample),
      .data_bit_q      (data_bit_q)
   );

endmodule

// ==== logic/apb_ctrl_regs.sv ====
`timescale 1ns/1ps

module apb_ctrl_regs import dds_lab_pkg::*; (
   input  logic                      video_clk_40Mhz,
   input  logic                      reset_from_key,
   input  logic                      psel,
   input  logic                      penable,
   input  logic                      pwrite,
   input  logic [apb_addr_width-1:0] paddr,
   input  logic [31:0]               pwdata,
   input  logic [num_keys-1:0]       held_keys,
   output logic [31:0]               prdata,
   output mode_reg_u                 mode,
   output logic [31:0]               base_word,
   output logic [31:0]               fsk_word,
   output logic [31:0]               bit_period
);

   logic wr_en;
   logic rd_en;

   // zero wait states, access phase completes the transfer
   assign wr_en = psel & penable & pwrite;
   assign rd_en = psel & penable & ~pwrite;

   //////////////////////////////////////////////////
   // writable registers
   //////////////////////////////////////////////////
   always_ff @(posedge video_clk_40Mhz) begin
      if (reset_from_key) begin
         mode.raw   <= '0;  // sine, ask
         base_word  <= base_word_reset;
         fsk_word   <= fsk_word_reset;
         bit_period <= bit_period_reset;
      end else if (wr_en) begin
         case (paddr)
            reg_mode:       mode.raw   <= pwdata & mode_write_mask;
            reg_base_word:  base_word  <= pwdata;
            reg_fsk_word:   fsk_word   <= pwdata;
            reg_bit_period: bit_period <= pwdata;
            default: ;  // keys and unmapped offsets drop the write
         endcase
      end
   end

   //////////////////////////////////////////////////
   // read mux
   //////////////////////////////////////////////////
   always_comb begin
      prdata = '0;
      if (rd_en) begin
         case (paddr)
            reg_mode:       prdata = mode.raw;
            reg_base_word:  prdata = base_word;
            reg_fsk_word:   prdata = fsk_word;
            reg_bit_period: prdata = bit_period;
            reg_keys:       prdata = {{(32-num_keys){1'b0}}, held_keys};
            default:        prdata = '0;  // unmapped reads zero
         endcase
      end
   end

   // every access phase comes right after its setup phase
   a_apb_phase: assert property (@(posedge video_clk_40Mhz) disable iff (reset_from_key)
      penable |-> psel && $past(psel && !penable))
      else $error("penable without a preceding setup phase");

endmodule

// ==== logic/key_hold_tracker.sv ====
`timescale 1ns/1ps

module key_hold_tracker import dds_lab_pkg::*; (
   input  logic                video_clk_40Mhz,
   input  logic                reset_from_key,
   input  logic                key_event_valid,
   input  logic [7:0]          key_event_code,
   output logic [num_keys-1:0] held_keys
);

   logic [num_keys-1:0] make_hit;
   logic [num_keys-1:0] break_hit;

   //////////////////////////////////////////////////
   // code match against the key table
   //////////////////////////////////////////////////
   always_comb begin
      for (int i = 0; i < num_keys; i++) begin
         make_hit[i]  = (key_event_code == key_make_codes[i]);
         break_hit[i] = (key_event_code == {1'b1, key_make_codes[i][6:0]});  // bit 7 marks release
      end
   end

   // unknown codes match nothing and leave the flags alone
   always_ff @(posedge video_clk_40Mhz) begin
      if (reset_from_key) begin
         held_keys <= '0;
      end else if (key_event_valid) begin
         held_keys <= (held_keys | make_hit) & ~break_hit;
      end
   end

endmodule

// ==== logic/modulation_select.sv ====
`timescale 1ns/1ps

module modulation_select import dds_lab_pkg::*; (
   input  logic                    video_clk_40Mhz,
   input  logic                    reset_from_key,
   input  mode_reg_u               mode,
   input  logic [phase_width-1:0]  base_word,
   input  logic [phase_width-1:0]  fsk_word,
   input  logic [sample_width-1:0] sin_in,
   input  logic [sample_width-1:0] cos_in,
   input  logic [sample_width-1:0] saw_in,
   input  logic [sample_width-1:0] squ_in,
   input  logic                    data_bit,
   output logic [phase_width-1:0]  phase_inc,
   output logic [sample_width-1:0] mod_sample,
   output logic [sample_width-1:0] wave_sample,
   output logic                    data_bit_q
);

   logic [sample_width-1:0] mod_next;
   logic [sample_width-1:0] wave_next;

   // fsk keys the frequency, every other mode runs at the base rate
   assign phase_inc = (mode.fields.mod_sel == mod_sel_fsk) ? fsk_word : base_word;

   //////////////////////////////////////////////////
   // modulated sample
   //////////////////////////////////////////////////
   always_comb begin
      case (mode.fields.mod_sel)
         mod_sel_ask:  mod_next = data_bit ? sin_in : '0;
         mod_sel_fsk:  mod_next = sin_in;  // frequency already switched
         mod_sel_bpsk: mod_next = data_bit ? sin_in : ~sin_in;  // inverted about mid scale
         default:      mod_next = data_bit ? '0 : lfsr_low_sample;
      endcase
   end

   // plain waveform
   always_comb begin
      case (mode.fields.sig_sel)
         sig_sel_sine:   wave_next = sin_in;
         sig_sel_cosine: wave_next = cos_in;
         sig_sel_saw:    wave_next = saw_in;
         default:        wave_next = squ_in;
      endcase
   end

   //////////////////////////////////////////////////
   // output registers, all on one edge
   //////////////////////////////////////////////////
   always_ff @(posedge video_clk_40Mhz) begin
      if (reset_from_key) begin
         mod_sample  <= '0;
         wave_sample <= '0;
         data_bit_q  <= lfsr_seed[0];  // same bit the lfsr starts on
      end else begin
         mod_sample  <= mod_next;
         wave_sample <= wave_next;
         data_bit_q  <= data_bit;
      end
   end

   // ask gates the carrier off for a zero bit
   a_ask_zero: assert property (@(posedge video_clk_40Mhz) disable iff (reset_from_key)
      (mode.fields.mod_sel == mod_sel_ask && !data_bit) |=> (mod_sample == '0))
      else $error("ask output not zero after a zero bit");

endmodule

// ==== logic/lfsr_bit_source.sv ====
`timescale 1ns/1ps

module lfsr_bit_source import dds_lab_pkg::*; (
   input  logic        video_clk_40Mhz,
   input  logic        reset_from_key,
   input  logic [31:0] bit_period,
   output logic        data_bit
);

   logic [31:0]           period_eff;
   logic [31:0]           count_q;
   logic                  wrap;
   logic [lfsr_width-1:0] lfsr_q;

   assign period_eff = (bit_period == '0) ? 32'd1 : bit_period;  // zero acts as one
   assign wrap       = (count_q >= period_eff - 32'd1);  // >= so a shorter period wraps at once

   always_ff @(posedge video_clk_40Mhz) begin
      if (reset_from_key) begin
         count_q <= '0;
         lfsr_q  <= lfsr_seed;
      end else if (wrap) begin
         count_q <= '0;
         // x^5 + x^3 + 1, feedback into bit 0
         lfsr_q  <= {lfsr_q[lfsr_width-2:0], lfsr_q[4] ^ lfsr_q[2]};
      end else begin
         count_q <= count_q + 32'd1;
      end
   end

   assign data_bit = lfsr_q[0];

   // the all zero state would lock the sequence
   a_lfsr_nonzero: assert property (@(posedge video_clk_40Mhz) disable iff (reset_from_key)
      lfsr_q != '0)
      else $error("lfsr reached the all zero state");

endmodule

// ==== logic/dds_wave_gen.sv ====
`timescale 1ns/1ps

module dds_wave_gen import dds_lab_pkg::*; (
   input  logic                    video_clk_40Mhz,
   input  logic                    reset_from_key,
   input  logic [phase_width-1:0]  phase_inc,
   output logic [sample_width-1:0] sin_out,
   output logic [sample_width-1:0] cos_out,
   output logic [sample_width-1:0] saw_out,
   output logic [sample_width-1:0] squ_out
);

   logic [phase_width-1:0] phase_q;
   logic [phase_width-1:0] cos_phase;

   //////////////////////////////////////////////////
   // phase accumulator
   //////////////////////////////////////////////////
   always_ff @(posedge video_clk_40Mhz) begin
      if (reset_from_key) begin
         phase_q <= '0;
      end else begin
         phase_q <= phase_q + phase_inc;  // wraps once per output period
      end
   end

   // full sine from the quarter table
   // bit 30 mirrors the address, bit 31 flips the offset binary half
   function automatic logic [sample_width-1:0] sine_lookup(
      input logic [phase_width-1:0] ph
   );
      logic [lut_addr_width-1:0] addr;
      logic [sample_width-1:0]   half;
      addr = ph[phase_width-3 -: lut_addr_width];
      if (ph[phase_width-2]) begin
         addr = ~addr;  // 63 - addr on the falling quarter
      end
      half = {1'b1, quarter_sine[addr]};
      // ~(2048 + t) is 2047 - t, the lower half of the wave
      return ph[phase_width-1] ? ~half : half;
   endfunction

   //////////////////////////////////////////////////
   // waveform outputs
   //////////////////////////////////////////////////
   assign cos_phase = phase_q + phase_quarter;  // cosine leads by a quarter turn

   always_comb begin
      sin_out = sine_lookup(phase_q);
      cos_out = sine_lookup(cos_phase);
   end

   assign saw_out = phase_q[phase_width-1 -: sample_width];  // top bits ramp up
   assign squ_out = {sample_width{phase_q[phase_width-1]}};  // full scale on second half

endmodule

// ==== logic/dds_lab_pkg.sv ====
package dds_lab_pkg;

   //////////////////////////////////////////////////
   // widths
   //////////////////////////////////////////////////
   localparam int phase_width    = 32;
   localparam int sample_width   = 12;
   localparam int lut_addr_width = 6;   // 64 entry quarter table
   localparam int lfsr_width     = 5;
   localparam int num_keys       = 17;
   localparam int apb_addr_width = 8;

   localparam logic [lfsr_width-1:0]   lfsr_seed       = 5'b00001;
   localparam logic [sample_width-1:0] lfsr_low_sample = 12'h800;
   localparam logic [phase_width-1:0]  phase_quarter   = 32'h4000_0000;  // 90 degrees

   // waveform and modulation codes
   localparam logic [1:0] sig_sel_sine   = 2'd0;
   localparam logic [1:0] sig_sel_cosine = 2'd1;
   localparam logic [1:0] sig_sel_saw    = 2'd2;
   localparam logic [1:0] sig_sel_square = 2'd3;
   localparam logic [1:0] mod_sel_ask    = 2'd0;
   localparam logic [1:0] mod_sel_fsk    = 2'd1;
   localparam logic [1:0] mod_sel_bpsk   = 2'd2;
   localparam logic [1:0] mod_sel_lfsr   = 2'd3;

   //////////////////////////////////////////////////
   // register map
   //////////////////////////////////////////////////
   localparam logic [apb_addr_width-1:0] reg_mode       = 8'h00;
   localparam logic [apb_addr_width-1:0] reg_base_word  = 8'h04;
   localparam logic [apb_addr_width-1:0] reg_fsk_word   = 8'h08;
   localparam logic [apb_addr_width-1:0] reg_bit_period = 8'h0C;
   localparam logic [apb_addr_width-1:0] reg_keys       = 8'h10;  // read only

   localparam logic [31:0] mode_write_mask   = 32'h0000_000F;  // sig_sel and mod_sel only
   localparam logic [31:0] base_word_reset   = 32'h0010_0000;
   localparam logic [31:0] fsk_word_reset    = 32'h0040_0000;
   localparam logic [31:0] bit_period_reset  = 32'd16;

   // mode word, seen raw by the bus and by field in the datapath
   typedef union packed {
      logic [31:0] raw;
      struct packed {
         logic [27:0] zero;
         logic [1:0]  mod_sel;
         logic [1:0]  sig_sel;
      } fields;
   } mode_reg_u;

   // make codes, flag order 1..8, f1, f2, n, m, space, left, right, up, down
   // break code is the make code with bit 7 set
   localparam logic [7:0] key_make_codes [num_keys] = '{
      8'h02, 8'h03, 8'h04, 8'h05, 8'h06, 8'h07, 8'h08, 8'h09,
      8'h3B, 8'h3C, 8'h31, 8'h32, 8'h39, 8'h4B, 8'h4D, 8'h48,
      8'h50
   };

   // first quarter of a sine, amplitude 2047, sampled at bin centres
   localparam logic [10:0] quarter_sine [64] = '{
      11'd25,   11'd75,   11'd126,  11'd176,  11'd226,  11'd275,  11'd325,  11'd375,
      11'd424,  11'd473,  11'd522,  11'd570,  11'd618,  11'd666,  11'd713,  11'd760,
      11'd807,  11'd852,  11'd898,  11'd943,  11'd987,  11'd1031, 11'd1074, 11'd1116,
      11'd1158, 11'd1199, 11'd1239, 11'd1279, 11'd1318, 11'd1356, 11'd1393, 11'd1430,
      11'd1465, 11'd1500, 11'd1533, 11'd1566, 11'd1598, 11'd1629, 11'd1659, 11'd1688,
      11'd1716, 11'd1743, 11'd1769, 11'd1793, 11'd1817, 11'd1840, 11'd1861, 11'd1881,
      11'd1901, 11'd1919, 11'd1936, 11'd1951, 11'd1966, 11'd1979, 11'd1992, 11'd2003,
      11'd2012, 11'd2021, 11'd2028, 11'd2035, 11'd2039, 11'd2043, 11'd2046, 11'd2047
   };

endpackage
